//--- compile.f
+incdir+.
opcode_pkg.sv
funct_pkg.sv
insn_decoder.sv
decode_stage_reg.sv
reg_file.sv
decode_top.sv
tb_decode_top.sv

//--- tb_decode_ref.svh
`ifndef TB_DECODE_REF_SVH
`define TB_DECODE_REF_SVH

logic [`DATA_W-1:0] model_regs [`NUM_REGS]; // Register file contents as expected

task automatic reset_model();
	for (int i = 0; i < `NUM_REGS; i++)
		model_regs[i] = i;
endtask

// Expected decoder outputs for one word with unused fields zero
function automatic void predict_decode(
	input  logic [`DATA_W-1:0]    w,
	output logic                  kn,
	output logic [`OP_W-1:0]      e_op, e_fn, e_alu,
	output logic [`REG_IDX_W-1:0] e_rs, e_rt, e_rd, e_sa, e_dst,
	output logic [`DATA_W-1:0]    e_imm,
	output logic [`TARGET_W-1:0]  e_tgt
);
	logic [`OP_W-1:0] o;
	logic [`OP_W-1:0] f;
	logic             listed;
	o = w[31:26];
	f = w[5:0];
	kn = 1'b0;
	{e_op, e_fn, e_alu, e_rs, e_rt, e_rd, e_sa, e_dst, e_imm, e_tgt} = '0;
	case (f)
		ADD, ADDU, SUB, SUBU, MULT, MULTU, DIV, DIVU, MFHI, MFLO, SLT, SLTU,
		SLL, SLLV, SRL, SRLV, SRA, SRAV, AND, OR, XOR, NOR, JR, JALR: listed = 1'b1;
		default: listed = 1'b0;
	endcase
	if ((o == OP_SPECIAL && listed) || (o == OP_SPECIAL2 && f == F_MUL)) begin
		kn = 1'b1;
		e_op = o;
		e_fn = f;
		e_alu = f;
		e_rs = w[25:21];
		e_rt = w[20:16];
		e_rd = w[15:11];
		if (o == OP_SPECIAL) begin // MUL keeps every field
			if (f == MFHI || f == MFLO || f == SLL || f == SRL || f == SRA)
				e_rs = '0;
			if (f == MFHI || f == MFLO || f == JR)
				e_rt = '0;
			if (f == MULT || f == MULTU || f == DIV || f == DIVU || f == JR)
				e_rd = '0;
			if (f == SLL || f == SRL || f == SRA)
				e_sa = w[10:6];
		end
		e_dst = e_rd;
	end else begin
		case (o)
			ADDI, ADDIU, SLTI, SLTIU, ORI, XORI, LW, SW, LB, LBU, SB, LUI,
			BEQ, BNE, BGTZ: begin
				kn = 1'b1;
				e_op = o;
				e_alu = o;
				e_rs = (o == LUI) ? '0 : w[25:21];
				e_rt = w[20:16];
				e_dst = w[20:16];
				e_imm = {{16{w[15]}}, w[15:0]};
			end
			J, JAL: begin
				kn = 1'b1;
				e_op = o;
				e_alu = o;
				e_tgt = w[25:0];
			end
			default: kn = 1'b0;
		endcase
	end
endfunction

function automatic logic predicts_known(input logic [`DATA_W-1:0] w);
	logic                  kn;
	logic [`OP_W-1:0]      a, b, c;
	logic [`REG_IDX_W-1:0] d, e, g, h, k;
	logic [`DATA_W-1:0]    m;
	logic [`TARGET_W-1:0]  t;
	predict_decode(w, kn, a, b, c, d, e, g, h, k, m, t);
	return kn;
endfunction

`endif

//--- tb_decode_top.sv
`timescale 1ns/1ps
`include "decode_defines.svh"

module tb_decode_top;
	import opcode_pkg::*;
	import funct_pkg::*;

	`include "tb_decode_ref.svh"

	localparam int CYCLE_LIMIT = 2000;

	logic                  clock;
	logic                  rst_n;
	logic                  decode_en;
	logic                  we;
	logic [`DATA_W-1:0]    pc, wdata, insn;
	logic [`OP_W-1:0]      opcode, func, alu_op;
	logic [`REG_IDX_W-1:0] rs, rt, rd, sa;
	logic [`DATA_W-1:0]    imm_sx, pc_q, insn_q, rs_data, rt_data;
	logic [`TARGET_W-1:0]  target;

	// Expected stage contents
	logic [`DATA_W-1:0]    x_pc, x_insn, x_imm;
	logic [`OP_W-1:0]      x_op, x_fn, x_alu, p_op, p_fn, p_alu;
	logic [`REG_IDX_W-1:0] x_rs, x_rt, x_rd, x_sa, x_dst, p_rs, p_rt, p_rd, p_sa, p_dst;
	logic [`DATA_W-1:0]    p_imm;
	logic [`TARGET_W-1:0]  x_tgt, p_tgt;
	logic                  p_kn;

	integer seed;
	int     errors;
	int     checks;
	int     tests;
	int     err_mark;
	int     cycles;

	decode_top u_dut (
		.clock(clock), .rst_n(rst_n), .decode_en(decode_en), .we(we),
		.pc(pc), .wdata(wdata), .insn(insn),
		.opcode(opcode), .func(func), .alu_op(alu_op),
		.rs(rs), .rt(rt), .rd(rd), .sa(sa),
		.imm_sx(imm_sx), .pc_q(pc_q), .insn_q(insn_q),
		.rs_data(rs_data), .rt_data(rt_data), .target(target)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	task automatic compare_value(input string name, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		checks++;
		if (act_val !== exp_val) begin
			errors++;
			$display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp_val, act_val);
		end
	endtask

	// Advance the model on the same edges as the DUT
	always @(posedge clock) begin
		if (!rst_n) begin
			reset_model();
			{x_pc, x_insn, x_op, x_fn, x_alu, x_rs, x_rt, x_rd, x_sa, x_dst, x_imm, x_tgt} = '0;
		end else begin
			if (we)
				model_regs[x_dst] = wdata; // Dest from before this edge
			if (decode_en) begin
				x_pc = pc;
				x_insn = insn;
				predict_decode(insn, p_kn, p_op, p_fn, p_alu, p_rs, p_rt, p_rd, p_sa,
					p_dst, p_imm, p_tgt);
				if (p_kn) begin
					{x_op, x_fn, x_alu, x_rs, x_rt, x_rd} = {p_op, p_fn, p_alu, p_rs, p_rt, p_rd};
					{x_sa, x_dst, x_imm, x_tgt} = {p_sa, p_dst, p_imm, p_tgt};
				end
			end
		end
	end

	always @(negedge clock) begin
		if (rst_n) begin
			compare_value("pc_q", x_pc, pc_q);
			compare_value("insn_q", x_insn, insn_q);
			compare_value("opcode", x_op, opcode);
			compare_value("func", x_fn, func);
			compare_value("alu_op", x_alu, alu_op);
			compare_value("rs", x_rs, rs);
			compare_value("rt", x_rt, rt);
			compare_value("rd", x_rd, rd);
			compare_value("sa", x_sa, sa);
			compare_value("imm_sx", x_imm, imm_sx);
			compare_value("target", x_tgt, target);
			compare_value("rs_data", model_regs[x_rs], rs_data);
			compare_value("rt_data", model_regs[x_rt], rt_data);
		end
	end

	task automatic apply_cycle(input logic en, input logic [31:0] word, input logic w_en,
		input logic [31:0] w_data);
		decode_en = en;
		insn = word;
		we = w_en;
		wdata = w_data;
		pc = pc + 4;
		@(posedge clock);
		#1;
	endtask

	task automatic end_test(input string name);
		apply_cycle(1'b0, insn, 1'b0, wdata); // Last result checked here
		tests++;
		$display("test %0d %s: %0d errors", tests, name, errors - err_mark);
		err_mark = errors;
	endtask

	task automatic sweep_rtype();
		logic [`OP_W-1:0] codes [24];
		logic [31:0]      r;
		codes = '{ADD, ADDU, SUB, SUBU, MULT, MULTU, DIV, DIVU, MFHI, MFLO, SLT, SLTU,
			SLL, SLLV, SRL, SRLV, SRA, SRAV, AND, OR, XOR, NOR, JR, JALR};
		foreach (codes[k]) begin
			r = $random(seed);
			apply_cycle(1'b1, {OP_SPECIAL, r[25:6], codes[k]}, 1'b0, '0);
		end
		apply_cycle(1'b1, 32'h0, 1'b0, '0); // SLL
		end_test("R-type function codes");
	endtask

	task automatic sweep_itype();
		logic [`OP_W-1:0] codes [15];
		logic [31:0]      r;
		codes = '{ADDI, ADDIU, SLTI, SLTIU, ORI, XORI, LW, SW, LB, LBU, SB, LUI, BEQ, BNE, BGTZ};
		foreach (codes[k]) begin
			r = $random(seed);
			apply_cycle(1'b1, {codes[k], r[25:16], 1'b0, r[14:0]}, 1'b0, '0);
			apply_cycle(1'b1, {codes[k], r[25:16], 1'b1, r[14:0]}, 1'b0, '0);
		end
		end_test("I-type opcodes");
	endtask

	task automatic decode_jumps();
		logic [31:0] r;
		r = $random(seed);
		apply_cycle(1'b1, {J, r[25:0]}, 1'b0, '0);
		apply_cycle(1'b1, {JAL, ~r[25:0]}, 1'b0, '0);
		apply_cycle(1'b1, {OP_SPECIAL2, r[25:6], F_MUL}, 1'b0, '0);
		apply_cycle(1'b1, {OP_SPECIAL, r[25:6], SRL}, 1'b0, '0); // Decodes as SRL here
		end_test("J, JAL, MUL and SRL");
	endtask

	task automatic hold_unknown();
		logic [31:0] r;
		for (int k = 0; k < 30; k++) begin
			do
				r = $random(seed);
			while (predicts_known(r));
			apply_cycle(1'b1, r, 1'b0, '0);
		end
		for (int k = 0; k < 8; k++)
			apply_cycle(1'b0, $random(seed), 1'b0, '0);
		end_test("unknown words and stalls");
	endtask

	task automatic exercise_reg_file();
		logic [31:0]           r;
		logic [`REG_IDX_W-1:0] prev;
		prev = 5'd7;
		apply_cycle(1'b1, {OP_SPECIAL, 5'd1, 5'd2, prev, 5'd0, ADD}, 1'b0, '0);
		for (int k = 0; k < 40; k++) begin
			r = $random(seed);
			// Reads the register written on the same edge
			if (k % 2 == 0)
				apply_cycle(1'b1, {OP_SPECIAL, prev, prev, r[4:0], 5'd0, ADD}, 1'b1, $random(seed));
			else
				apply_cycle(1'b1, {ADDI, prev, r[4:0], r[20:5]}, 1'b1, $random(seed));
			prev = r[4:0];
		end
		end_test("register file writes");
	endtask

	initial begin
		seed = 32'h4097;
		{errors, checks, tests, err_mark} = '0;
		rst_n = 1'b0;
		decode_en = 1'b0;
		we = 1'b0;
		pc = '0;
		wdata = '0;
		insn = '0;
		repeat (10) @(posedge clock);
		#1;
		rst_n = 1'b1;
		apply_cycle(1'b0, '0, 1'b0, '0);
		// Every register still holds its own index
		for (int k = 0; k < `NUM_REGS; k += 2)
			apply_cycle(1'b1, {OP_SPECIAL, 5'(k), 5'(k + 1), 5'd0, 5'd0, OR}, 1'b0, '0);
		end_test("reset state");
		sweep_rtype();
		sweep_itype();
		decode_jumps();
		hold_unknown();
		exercise_reg_file();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clock);
			cycles++;
		end
		$display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- decode_top.sv
`timescale 1ns/1ps
`include "decode_defines.svh"

module decode_top (
	input  logic                      clock,
	input  logic                      rst_n,
	input  logic                      decode_en,
	input  logic                      we,
	input  logic [`DATA_W-1:0]        pc,
	input  logic [`DATA_W-1:0]        wdata,
	input  opcode_pkg::insn_t         insn,
	output logic [`OP_W-1:0]          opcode,
	output logic [`OP_W-1:0]          func,
	output logic [`OP_W-1:0]          alu_op,
	output logic [`REG_IDX_W-1:0]     rs,
	output logic [`REG_IDX_W-1:0]     rt,
	output logic [`REG_IDX_W-1:0]     rd,
	output logic [`REG_IDX_W-1:0]     sa,
	output logic [`DATA_W-1:0]        imm_sx,
	output logic [`DATA_W-1:0]        pc_q,
	output logic [`DATA_W-1:0]        insn_q,
	output logic [`DATA_W-1:0]        rs_data,
	output logic [`DATA_W-1:0]        rt_data,
	output logic [`TARGET_W-1:0]      target
);

	logic                  dec_known;
	logic [`OP_W-1:0]      dec_opcode;
	logic [`OP_W-1:0]      dec_func;
	logic [`OP_W-1:0]      dec_alu_op;
	logic [`REG_IDX_W-1:0] dec_rs;
	logic [`REG_IDX_W-1:0] dec_rt;
	logic [`REG_IDX_W-1:0] dec_rd;
	logic [`REG_IDX_W-1:0] dec_sa;
	logic [`REG_IDX_W-1:0] dec_dest;
	logic [`DATA_W-1:0]    dec_imm_sx;
	logic [`TARGET_W-1:0]  dec_target;
	logic [`REG_IDX_W-1:0] dest_q; // Write index for the register file

	insn_decoder u_insn_decoder (
		.insn   (insn),
		.known  (dec_known),
		.opcode (dec_opcode),
		.func   (dec_func),
		.alu_op (dec_alu_op),
		.rs     (dec_rs),
		.rt     (dec_rt),
		.rd     (dec_rd),
		.sa     (dec_sa),
		.dest   (dec_dest),
		.imm_sx (dec_imm_sx),
		.target (dec_target)
	);

	decode_stage_reg u_stage_reg (
		.clock     (clock),
		.rst_n     (rst_n),
		.decode_en (decode_en),
		.known     (dec_known),
		.pc        (pc),
		.insn      (insn),
		.opcode    (dec_opcode),
		.func      (dec_func),
		.alu_op    (dec_alu_op),
		.rs        (dec_rs),
		.rt        (dec_rt),
		.rd        (dec_rd),
		.sa        (dec_sa),
		.dest      (dec_dest),
		.imm_sx    (dec_imm_sx),
		.target    (dec_target),
		.pc_q      (pc_q),
		.insn_q    (insn_q),
		.opcode_q  (opcode),
		.func_q    (func),
		.alu_op_q  (alu_op),
		.rs_q      (rs),
		.rt_q      (rt),
		.rd_q      (rd),
		.sa_q      (sa),
		.dest_q    (dest_q),
		.imm_sx_q  (imm_sx),
		.target_q  (target)
	);

	reg_file u_reg_file (
		.clock   (clock),
		.rst_n   (rst_n),
		.we      (we),
		.rs      (rs),
		.rt      (rt),
		.dest    (dest_q),
		.wdata   (wdata),
		.rs_data (rs_data),
		.rt_data (rt_data)
	);

endmodule

//--- reg_file.sv
`timescale 1ns/1ps
`include "decode_defines.svh"

module reg_file (
	input  logic                      clock,
	input  logic                      rst_n,
	input  logic                      we,
	input  logic [`REG_IDX_W-1:0]     rs,
	input  logic [`REG_IDX_W-1:0]     rt,
	input  logic [`REG_IDX_W-1:0]     dest,
	input  logic [`DATA_W-1:0]        wdata,
	output logic [`DATA_W-1:0]        rs_data,
	output logic [`DATA_W-1:0]        rt_data
);

	logic [`DATA_W-1:0] regs [`NUM_REGS];

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= `DATA_W'(i); // Register i holds i
			end
		end else if (we) begin
			regs[dest] <= wdata;
		end
	end

	assign rs_data = regs[rs];
	assign rt_data = regs[rt];

	a_wdata_known: assert property (@(posedge clock) disable iff (!rst_n)
		we |-> !$isunknown(wdata))
		else $error("write with unknown wdata");

endmodule

//--- decode_stage_reg.sv
`timescale 1ns/1ps
`include "decode_defines.svh"

module decode_stage_reg (
	input  logic                      clock,
	input  logic                      rst_n,
	input  logic                      decode_en,
	input  logic                      known,
	input  logic [`DATA_W-1:0]        pc,
	input  opcode_pkg::insn_t         insn,
	input  logic [`OP_W-1:0]          opcode,
	input  logic [`OP_W-1:0]          func,
	input  logic [`OP_W-1:0]          alu_op,
	input  logic [`REG_IDX_W-1:0]     rs,
	input  logic [`REG_IDX_W-1:0]     rt,
	input  logic [`REG_IDX_W-1:0]     rd,
	input  logic [`REG_IDX_W-1:0]     sa,
	input  logic [`REG_IDX_W-1:0]     dest,
	input  logic [`DATA_W-1:0]        imm_sx,
	input  logic [`TARGET_W-1:0]      target,
	output logic [`DATA_W-1:0]        pc_q,
	output logic [`DATA_W-1:0]        insn_q,
	output logic [`OP_W-1:0]          opcode_q,
	output logic [`OP_W-1:0]          func_q,
	output logic [`OP_W-1:0]          alu_op_q,
	output logic [`REG_IDX_W-1:0]     rs_q,
	output logic [`REG_IDX_W-1:0]     rt_q,
	output logic [`REG_IDX_W-1:0]     rd_q,
	output logic [`REG_IDX_W-1:0]     sa_q,
	output logic [`REG_IDX_W-1:0]     dest_q,
	output logic [`DATA_W-1:0]        imm_sx_q,
	output logic [`TARGET_W-1:0]      target_q
);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			pc_q     <= '0;
			insn_q   <= '0;
			opcode_q <= '0;
			func_q   <= '0;
			alu_op_q <= '0; // Inactive ALU operation
			rs_q     <= '0;
			rt_q     <= '0;
			rd_q     <= '0;
			sa_q     <= '0;
			dest_q   <= '0;
			imm_sx_q <= '0;
			target_q <= '0;
		end else if (decode_en) begin
			pc_q   <= pc;
			insn_q <= insn;
			if (known) begin // Unknown words keep the last fields
				opcode_q <= opcode;
				func_q   <= func;
				alu_op_q <= alu_op;
				rs_q     <= rs;
				rt_q     <= rt;
				rd_q     <= rd;
				sa_q     <= sa;
				dest_q   <= dest;
				imm_sx_q <= imm_sx;
				target_q <= target;
			end
		end
	end

	a_insn_capture: assert property (@(posedge clock) disable iff (!rst_n)
		decode_en |=> (insn_q == $past(insn)))
		else $error("insn_q missed the enabled word");

	a_stall_hold: assert property (@(posedge clock) disable iff (!rst_n)
		!decode_en |=> $stable({pc_q, insn_q, opcode_q, func_q, alu_op_q, rs_q, rt_q,
			rd_q, sa_q, dest_q, imm_sx_q, target_q}))
		else $error("stage changed while decode_en low");

endmodule

//--- insn_decoder.sv
`timescale 1ns/1ps
`include "decode_defines.svh"

module insn_decoder (
	input  opcode_pkg::insn_t         insn,
	output logic                      known,
	output logic [`OP_W-1:0]          opcode,
	output logic [`OP_W-1:0]          func,
	output logic [`OP_W-1:0]          alu_op,
	output logic [`REG_IDX_W-1:0]     rs,
	output logic [`REG_IDX_W-1:0]     rt,
	output logic [`REG_IDX_W-1:0]     rd,
	output logic [`REG_IDX_W-1:0]     sa,
	output logic [`REG_IDX_W-1:0]     dest,
	output logic [`DATA_W-1:0]        imm_sx,
	output logic [`TARGET_W-1:0]      target
);
	import opcode_pkg::*;
	import funct_pkg::*;

	logic r_type;
	logic i_type;
	logic j_type;
	logic zero_rs;
	logic zero_rt;
	logic zero_rd;
	logic use_sa;

	// R-type classification and per-function zeroing
	always_comb begin
		r_type  = 1'b0;
		zero_rs = 1'b0;
		zero_rt = 1'b0;
		zero_rd = 1'b0;
		use_sa  = 1'b0;
		if (insn.r.opcode == OP_SPECIAL) begin
			case (insn.r.funct)
				ADD, ADDU, SUB, SUBU, SLT, SLTU, SLLV, SRLV, SRAV,
				AND, OR, XOR, NOR, JALR: begin
					r_type = 1'b1;
				end
				MULT, MULTU, DIV, DIVU: begin
					r_type  = 1'b1;
					zero_rd = 1'b1; // HI/LO destination
				end
				MFHI, MFLO: begin
					r_type  = 1'b1;
					zero_rs = 1'b1;
					zero_rt = 1'b1;
				end
				SLL, SRL, SRA: begin
					r_type  = 1'b1;
					zero_rs = 1'b1;
					use_sa  = 1'b1; // Immediate shift amount
				end
				JR: begin
					r_type  = 1'b1;
					zero_rt = 1'b1;
					zero_rd = 1'b1;
				end
				default: begin
					r_type = 1'b0;
				end
			endcase
		end else if (insn.r.opcode == OP_SPECIAL2) begin
			r_type = (insn.r.funct == F_MUL);
		end
	end

	always_comb begin
		case (insn.i.opcode)
			ADDI, ADDIU, SLTI, SLTIU, ORI, XORI, LW, SW, LB, LBU, SB, LUI,
			BEQ, BNE, BGTZ: i_type = 1'b1;
			default:        i_type = 1'b0;
		endcase
		j_type = (insn.j.opcode == J) || (insn.j.opcode == JAL);
	end

	// Unused fields read as zero
	always_comb begin
		known  = r_type | i_type | j_type;
		opcode = '0;
		func   = '0;
		alu_op = '0;
		rs     = '0;
		rt     = '0;
		rd     = '0;
		sa     = '0;
		dest   = '0;
		imm_sx = '0;
		target = '0;
		if (r_type) begin
			opcode = insn.r.opcode;
			func   = insn.r.funct;
			alu_op = insn.r.funct;
			rs     = zero_rs ? '0 : insn.r.rs;
			rt     = zero_rt ? '0 : insn.r.rt;
			rd     = zero_rd ? '0 : insn.r.rd;
			sa     = use_sa ? insn.r.shamt : '0;
			dest   = zero_rd ? '0 : insn.r.rd;
		end else if (i_type) begin
			opcode = insn.i.opcode;
			alu_op = insn.i.opcode;
			rs     = (insn.i.opcode == LUI) ? '0 : insn.i.rs;
			rt     = insn.i.rt;
			dest   = insn.i.rt; // Loads and ALU-imm write rt
			imm_sx = {{(`DATA_W-`IMM_W){insn.i.imm[`IMM_W-1]}}, insn.i.imm};
		end else if (j_type) begin
			opcode = insn.j.opcode;
			alu_op = insn.j.opcode;
			target = insn.j.target;
		end
	end

	// Sampled whenever the word changes
	a_jump_no_dest: assert property (@(insn)
		(known && (insn.j.opcode == J || insn.j.opcode == JAL)) |-> (dest == '0))
		else $error("jump decoded with nonzero dest");

endmodule

//--- funct_pkg.sv
`include "decode_defines.svh"

package funct_pkg;

	// Arithmetic
	localparam logic [`OP_W-1:0] ADD   = 6'b100000;
	localparam logic [`OP_W-1:0] ADDU  = 6'b100001;
	localparam logic [`OP_W-1:0] SUB   = 6'b100010;
	localparam logic [`OP_W-1:0] SUBU  = 6'b100011;
	localparam logic [`OP_W-1:0] MULT  = 6'b011000; // Result to HI/LO
	localparam logic [`OP_W-1:0] MULTU = 6'b011001;
	localparam logic [`OP_W-1:0] DIV   = 6'b011010;
	localparam logic [`OP_W-1:0] DIVU  = 6'b011011;

	localparam logic [`OP_W-1:0] MFHI  = 6'b010000;
	localparam logic [`OP_W-1:0] MFLO  = 6'b010010;

	localparam logic [`OP_W-1:0] SLT   = 6'b101010;
	localparam logic [`OP_W-1:0] SLTU  = 6'b101011;

	// V forms take the shift amount from rs
	localparam logic [`OP_W-1:0] SLL   = 6'b000000;
	localparam logic [`OP_W-1:0] SLLV  = 6'b000100;
	localparam logic [`OP_W-1:0] SRL   = 6'b000010;
	localparam logic [`OP_W-1:0] SRLV  = 6'b000110;
	localparam logic [`OP_W-1:0] SRA   = 6'b000011;
	localparam logic [`OP_W-1:0] SRAV  = 6'b000111;

	localparam logic [`OP_W-1:0] AND   = 6'b100100;
	localparam logic [`OP_W-1:0] OR    = 6'b100101;
	localparam logic [`OP_W-1:0] XOR   = 6'b100110;
	localparam logic [`OP_W-1:0] NOR   = 6'b100111;

	localparam logic [`OP_W-1:0] JR    = 6'b001000;
	localparam logic [`OP_W-1:0] JALR  = 6'b001001;

	// Shares the SRL code but only under OP_SPECIAL2
	localparam logic [`OP_W-1:0] F_MUL = 6'b000010;

endpackage

//--- opcode_pkg.sv
`include "decode_defines.svh"

package opcode_pkg;

	// R view of the word
	typedef struct packed {
		logic [`OP_W-1:0]      opcode;
		logic [`REG_IDX_W-1:0] rs;
		logic [`REG_IDX_W-1:0] rt;
		logic [`REG_IDX_W-1:0] rd;
		logic [`REG_IDX_W-1:0] shamt;
		logic [`OP_W-1:0]      funct;
	} insn_r_t;

	typedef struct packed {
		logic [`OP_W-1:0]      opcode;
		logic [`REG_IDX_W-1:0] rs;
		logic [`REG_IDX_W-1:0] rt;
		logic [`IMM_W-1:0]     imm;
	} insn_i_t;

	typedef struct packed {
		logic [`OP_W-1:0]     opcode;
		logic [`TARGET_W-1:0] target;
	} insn_j_t;

	typedef union packed {
		insn_r_t r;
		insn_i_t i;
		insn_j_t j;
	} insn_t;

	localparam logic [`OP_W-1:0] OP_SPECIAL  = 6'b000000; // R-type group
	localparam logic [`OP_W-1:0] OP_SPECIAL2 = 6'b011100; // MUL lives here
	localparam logic [`OP_W-1:0] ADDI        = 6'b001000;
	localparam logic [`OP_W-1:0] ADDIU       = 6'b001001;
	localparam logic [`OP_W-1:0] SLTI        = 6'b001010;
	localparam logic [`OP_W-1:0] SLTIU       = 6'b001011;
	localparam logic [`OP_W-1:0] ORI         = 6'b001101;
	localparam logic [`OP_W-1:0] XORI        = 6'b001110;
	localparam logic [`OP_W-1:0] LW          = 6'b100011;
	localparam logic [`OP_W-1:0] SW          = 6'b101011;
	localparam logic [`OP_W-1:0] LB          = 6'b100000;
	localparam logic [`OP_W-1:0] LBU         = 6'b100100;
	localparam logic [`OP_W-1:0] SB          = 6'b101000;
	localparam logic [`OP_W-1:0] LUI         = 6'b001111; // No base register
	localparam logic [`OP_W-1:0] BEQ         = 6'b000100;
	localparam logic [`OP_W-1:0] BNE         = 6'b000101;
	localparam logic [`OP_W-1:0] BGTZ        = 6'b000111;
	localparam logic [`OP_W-1:0] J           = 6'b000010;
	localparam logic [`OP_W-1:0] JAL         = 6'b000011;

endpackage

//--- decode_defines.svh
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// Datapath
`define DATA_W      32
`define NUM_REGS    32
`define REG_IDX_W   5

// Instruction fields
`define OP_W        6
`define IMM_W       16
`define TARGET_W    26

`endif
